// ==== hdl/knight_settings.svh ====
// Build-time constants for the knight command processor.
// Include this header in every RTL file that needs a width or a step size.
// FAST_SIM picks the large ramp and nudge steps for short simulations.

`ifndef KNIGHT_SETTINGS_SVH
`define KNIGHT_SETTINGS_SVH

////////////////////////////////
// Simulation speed select
////////////////////////////////
`define FAST_SIM 1                      // 1 = large steps, 0 = real robot steps.

////////////////////////////////
// Datapath widths
////////////////////////////////
`define FRWRD_W   10                    // Forward speed width.
`define HEADING_W 12                    // Gyro heading and PID error width.
`define SQ_W      4                     // Square count field of a move command.

////////////////////////////////
// Forward speed ramp steps
////////////////////////////////
`define INC_AMT ((`FAST_SIM != 0) ? 10'h020 : 10'h003)  // Added per heading update.
`define DEC_AMT ((`FAST_SIM != 0) ? 10'h040 : 10'h006)  // Removed per heading update.

////////////////////////////////
// IR nudge and alignment
////////////////////////////////
// Left IR sees the line, so steer the error positive.
`define NUDGE_POS ((`FAST_SIM != 0) ? 12'h1FF : 12'h05F)
// Right IR sees the line, so steer the error negative.
`define NUDGE_NEG ((`FAST_SIM != 0) ? 12'hE00 : 12'hFA1)

`define ALIGN_THRESH 12'h02C            // |error| below this counts as aligned.

`endif

// ==== hdl/knight_pkg.sv ====
// Shared types of the knight command processor.
// Opcodes, FSM states and the heading, speed and pulse count types.
`default_nettype none

`include "knight_settings.svh"

package knight_pkg;

  ////////////////////////////////
  // Command opcodes, cmd[15:12]
  ////////////////////////////////
  typedef enum logic [3:0] {
    CAL     = 4'h2,                     // Calibrate gyro.
    MOV     = 4'h4,                     // Plain move.
    FANFARE = 4'h5,                     // Move, then the charge tune.
    TOUR    = 6                         // Hand off to the tour logic.
  } opcode_t;

  ////////////////////////////////
  // Command FSM states
  ////////////////////////////////
  typedef enum logic [2:0] {
    IDLE,                               // Waiting for cmd_rdy.
    CALIBRATE,                          // Waiting for cal_done.
    MOVE,                               // Turning onto the new heading.
    INCR,                               // Ramping up, counting squares.
    DECR                                // Ramping down to a stop.
  } state_t;

  typedef logic signed [`HEADING_W-1:0] heading_t;  // Gyro heading or PID error.
  typedef logic [`FRWRD_W-1:0]          speed_t;    // Forward speed.
  typedef logic [`SQ_W:0]               pulse_cnt_t; // cntrIR edges, two per square.

endpackage

`default_nettype wire

// ==== hdl/cmd_fsm.sv ====
// Command FSM of the knight robot.
// Accepts one command at a time through cmd_rdy/clr_cmd_rdy and steers
// the square counter, the speed ramp and the heading logic until the
// command finishes with a send_resp pulse.
`timescale 1ns/1ps
`default_nettype none

`include "knight_settings.svh"

module cmd_fsm (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 cmd_rdy,      // Receiver holds a command.
  input  knight_pkg::opcode_t opcode,       // Live opcode field of cmd.
  input  wire                 cal_done,     // Gyro calibration finished.
  input  wire                 aligned,      // Heading error is small.
  input  wire                 move_done,    // Square count reached.
  input  wire                 frwrd_zero,   // Speed is back to zero.
  output logic                clr_cmd_rdy,  // Command consumed.
  output logic                strt_cal,
  output logic                tour_go,
  output logic                fanfare_go,
  output logic                send_resp,
  output logic                moving,
  output logic                load_move,    // Capture heading and squares.
  output logic                clr_frwrd,
  output logic                inc_frwrd,
  output logic                dec_frwrd
);

  import knight_pkg::*;

  state_t  state;                       // Current state.
  state_t  nxt_state;
  opcode_t op_q;                        // Opcode of the command in progress.

  ////////////////////////////////
  // State and opcode registers
  ////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      op_q  <= MOV;
    end else begin
      state <= nxt_state;
      if (clr_cmd_rdy)
        op_q <= opcode;                 // Latched at acceptance.
    end
  end

  ////////////////////////////////
  // Next state and control pulses
  ////////////////////////////////
  always_comb begin
    nxt_state   = state;
    clr_cmd_rdy = 1'b0;
    strt_cal    = 1'b0;
    tour_go     = 1'b0;
    fanfare_go  = 1'b0;
    send_resp   = 1'b0;
    moving      = 1'b0;
    load_move   = 1'b0;
    clr_frwrd   = 1'b0;
    inc_frwrd   = 1'b0;
    dec_frwrd   = 1'b0;

    case (state)
      CALIBRATE: begin
        if (cal_done) begin
          send_resp = 1'b1;             // Calibration done, answer.
          nxt_state = IDLE;
        end
      end

      MOVE: begin
        if (aligned) begin              // Only start rolling once pointed right.
          moving    = 1'b1;
          clr_frwrd = 1'b1;             // Ramp starts from a standstill.
          nxt_state = INCR;
        end
      end

      INCR: begin
        moving    = 1'b1;
        inc_frwrd = 1'b1;
        if (move_done) begin
          fanfare_go = (op_q == FANFARE); // Charge! at the last square.
          nxt_state  = DECR;
        end
      end

      DECR: begin
        dec_frwrd = 1'b1;
        if (frwrd_zero) begin
          send_resp = 1'b1;             // Stopped, move complete.
          nxt_state = IDLE;
        end else begin
          moving = 1'b1;                // Still coasting down.
        end
      end

      default: begin                    // IDLE.
        if (cmd_rdy) begin
          clr_cmd_rdy = 1'b1;           // Every command is consumed here.
          case (opcode)
            CAL: begin
              strt_cal  = 1'b1;
              nxt_state = CALIBRATE;
            end
            MOV, FANFARE: begin
              load_move = 1'b1;
              nxt_state = MOVE;
            end
            TOUR: tour_go = 1'b1;       // Tour logic takes over, stay idle.
            default: ;                  // Unknown opcode is dropped.
          endcase
        end
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/square_counter.sv ====
// Square counter of the knight robot.
// Counts rising edges of the center IR sensor after a move is loaded.
// Each square crosses two lines, so the move is done at twice the count.
`timescale 1ns/1ps
`default_nettype none

`include "knight_settings.svh"

module square_counter (
  input  wire            clk,
  input  wire            rst_n,
  input  wire            load_move,     // New move accepted.
  input  wire [`SQ_W-1:0] squares,      // Squares to travel, from cmd[3:0].
  input  wire            cntrIR,        // Center IR, high over a line.
  output logic           move_done
);

  import knight_pkg::*;

  logic             cntr_ir_q;          // Previous cntrIR sample.
  logic             cntr_rise;
  logic [`SQ_W-1:0] squares_q;          // Captured square count.
  pulse_cnt_t       pulse_cnt;          // Lines crossed in this move.

  ////////////////////////////////
  // Line edge detect
  ////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      cntr_ir_q <= 1'b0;
    else
      cntr_ir_q <= cntrIR;
  end

  assign cntr_rise = cntrIR & ~cntr_ir_q; // Low last cycle, high now.

  ////////////////////////////////
  // Move target and line count
  ////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      squares_q <= '0;
      pulse_cnt <= '0;
    end else if (load_move) begin
      squares_q <= squares;
      pulse_cnt <= '0;                  // Fresh count per move.
    end else if (cntr_rise) begin
      pulse_cnt <= pulse_cnt + 1'b1;
    end
  end

  assign move_done = (pulse_cnt == {squares_q, 1'b0}); // Two lines per square.

endmodule

`default_nettype wire

// ==== hdl/frwrd_ramp.sv ====
// Forward speed register of the knight robot.
// Ramps the speed up or down by one step per gyro heading update,
// as steered by the command FSM. Feeds the motor drive directly.
`timescale 1ns/1ps
`default_nettype none

`include "knight_settings.svh"

module frwrd_ramp (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                clr_frwrd,   // Start a ramp from zero.
  input  wire                inc_frwrd,   // Ramp up.
  input  wire                dec_frwrd,   // Ramp down.
  input  wire                heading_rdy, // Gyro update, paces the ramp.
  output knight_pkg::speed_t frwrd,
  output logic               frwrd_zero
);

  import knight_pkg::*;

  speed_t dec_step;                     // Never more than the speed itself.
  logic   at_max;

  assign dec_step   = (frwrd < `DEC_AMT) ? frwrd : `DEC_AMT;
  assign at_max     = &frwrd[`FRWRD_W-1:`FRWRD_W-2]; // Near top, stop adding.
  assign frwrd_zero = (frwrd == '0);

  ////////////////////////////////
  // Speed register
  ////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      frwrd <= '0;
    else if (clr_frwrd)
      frwrd <= '0;
    else if (heading_rdy) begin         // One step per heading sample.
      if (inc_frwrd) begin
        if (!at_max)
          frwrd <= frwrd + `INC_AMT;
      end else if (dec_frwrd) begin
        frwrd <= frwrd - dec_step;      // Saturates at zero.
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/heading_error.sv ====
// Heading error for the knight robot's PID.
// Holds the desired heading of the current move and forms
// error = heading - desired + IR nudge, wrapping in the heading width.
// aligned tells the FSM the turn is close enough to start rolling.
`timescale 1ns/1ps
`default_nettype none

`include "knight_settings.svh"

module heading_error (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  load_move,   // New move accepted.
  input  wire [7:0]            cmd_heading, // cmd[11:4].
  input  knight_pkg::heading_t heading,     // From the gyro.
  input  wire                  lftIR,       // Drifted left over a line.
  input  wire                  rghtIR,      // Drifted right over a line.
  output knight_pkg::heading_t error,
  output logic                 aligned
);

  import knight_pkg::*;

  heading_t               desired;      // Target heading of this move.
  heading_t               nudge;
  logic [`HEADING_W-1:0]  error_abs;    // Unsigned, so -2048 is never small.

  ////////////////////////////////
  // Desired heading
  ////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      desired <= '0;
    else if (load_move) begin
      if (cmd_heading == 8'h00)
        desired <= '0;                  // North is exactly zero.
      else
        desired <= {cmd_heading, 4'hF}; // Low nibble fills to the sector center.
    end
  end

  ////////////////////////////////
  // Error and alignment
  ////////////////////////////////
  always_comb begin
    if (lftIR)
      nudge = `NUDGE_POS;               // Left wins if both are high.
    else if (rghtIR)
      nudge = `NUDGE_NEG;
    else
      nudge = '0;
  end

  assign error     = heading - desired + nudge;
  assign error_abs = error[`HEADING_W-1] ? -error : error;
  assign aligned   = (error_abs < `ALIGN_THRESH);

endmodule

`default_nettype wire

// ==== hdl/cmd_proc.sv ====
// Command processor of the knight robot, top level.
// Takes 16-bit commands from the Bluetooth receiver: [15:12] opcode,
// [11:4] heading and [3:0] squares. Drives the PID error, forward
// speed and the cal, tour and fanfare starts, and answers with send_resp.
`timescale 1ns/1ps
`default_nettype none

`include "knight_settings.svh"

module cmd_proc (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire [15:0]           cmd,         // Command word from the receiver.
  input  wire                  cmd_rdy,
  output logic                 clr_cmd_rdy,
  output logic                 send_resp,
  output logic                 strt_cal,
  input  wire                  cal_done,
  input  knight_pkg::heading_t heading,
  input  wire                  heading_rdy, // One cycle per gyro sample.
  input  wire                  lftIR,
  input  wire                  cntrIR,
  input  wire                  rghtIR,
  output knight_pkg::heading_t error,       // To the PID.
  output knight_pkg::speed_t   frwrd,       // To the PID.
  output logic                 moving,      // Lets the gyro integrate yaw.
  output logic                 tour_go,
  output logic                 fanfare_go
);

  knight_pkg::opcode_t opcode;          // cmd[15:12] as an opcode.
  logic                load_move;
  logic                move_done;
  logic                aligned;
  logic                clr_frwrd;
  logic                inc_frwrd;
  logic                dec_frwrd;
  logic                frwrd_zero;

  assign opcode = knight_pkg::opcode_t'(cmd[15:12]);

  cmd_fsm u_cmd_fsm (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_rdy     (cmd_rdy),
    .opcode      (opcode),
    .cal_done    (cal_done),
    .aligned     (aligned),
    .move_done   (move_done),
    .frwrd_zero  (frwrd_zero),
    .clr_cmd_rdy (clr_cmd_rdy),
    .strt_cal    (strt_cal),
    .tour_go     (tour_go),
    .fanfare_go  (fanfare_go),
    .send_resp   (send_resp),
    .moving      (moving),
    .load_move   (load_move),
    .clr_frwrd   (clr_frwrd),
    .inc_frwrd   (inc_frwrd),
    .dec_frwrd   (dec_frwrd)
  );

  square_counter u_square_counter (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_move (load_move),
    .squares   (cmd[`SQ_W-1:0]),
    .cntrIR    (cntrIR),
    .move_done (move_done)
  );

  frwrd_ramp u_frwrd_ramp (
    .clk         (clk),
    .rst_n       (rst_n),
    .clr_frwrd   (clr_frwrd),
    .inc_frwrd   (inc_frwrd),
    .dec_frwrd   (dec_frwrd),
    .heading_rdy (heading_rdy),
    .frwrd       (frwrd),
    .frwrd_zero  (frwrd_zero)
  );

  heading_error u_heading_error (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_move   (load_move),
    .cmd_heading (cmd[11:4]),
    .heading     (heading),
    .lftIR       (lftIR),
    .rghtIR      (rghtIR),
    .error       (error),
    .aligned     (aligned)
  );

endmodule

`default_nettype wire

// ==== testbench/cmd_proc_properties.sv ====
// Concurrent checks on the knight command processor.
// Bound into cmd_proc. fail_cnt counts the assertions that failed.
`timescale 1ns/1ps
`default_nettype none

`include "knight_settings.svh"

module cmd_proc_properties (
  input wire                 clk,
  input wire                 rst_n,
  input wire                 cmd_rdy,
  input wire                 clr_cmd_rdy,
  input wire                 strt_cal,
  input wire                 tour_go,
  input wire                 send_resp,
  input wire                 moving,
  input wire                 heading_rdy,
  input wire                 clr_frwrd,
  input knight_pkg::speed_t  frwrd,
  input knight_pkg::state_t  state       // FSM state, from inside cmd_fsm.
);

  import knight_pkg::*;

  int unsigned fail_cnt = 0;             // Failed assertions so far.

  ////////////////////////////////
  // Command handshake
  ////////////////////////////////
  a_accept: assert property (@(posedge clk) disable iff (!rst_n)
    clr_cmd_rdy == (cmd_rdy && (state == IDLE)))
    else begin
      fail_cnt++;
      $error("clr_cmd_rdy does not match cmd_rdy in IDLE");
    end
  a_accept_once: assert property (@(posedge clk) disable iff (!rst_n)
    clr_cmd_rdy |=> !clr_cmd_rdy)
    else begin
      fail_cnt++;
      $error("clr_cmd_rdy high for two cycles");
    end
  a_starts: assert property (@(posedge clk) disable iff (!rst_n)
    (strt_cal || tour_go) |-> clr_cmd_rdy)
    else begin
      fail_cnt++;
      $error("strt_cal or tour_go outside the accept cycle");
    end
  a_cal_still: assert property (@(posedge clk) disable iff (!rst_n)
    (state == CALIBRATE) |-> !moving)
    else begin
      fail_cnt++;
      $error("moving raised during calibration");
    end

  ////////////////////////////////
  // Forward speed
  ////////////////////////////////
  a_idle_stopped: assert property (@(posedge clk) disable iff (!rst_n)
    (state == IDLE || send_resp) |-> (frwrd == '0))
    else begin
      fail_cnt++;
      $error("speed not zero while idle or at send_resp");
    end
  a_frwrd_paced: assert property (@(posedge clk) disable iff (!rst_n)
    (frwrd != $past(frwrd)) |-> ($past(heading_rdy) || $past(clr_frwrd)))
    else begin
      fail_cnt++;
      $error("speed changed without a heading update");
    end
  a_frwrd_step: assert property (@(posedge clk) disable iff (!rst_n)
    (frwrd != $past(frwrd)) |-> ((frwrd == speed_t'($past(frwrd) + `INC_AMT)) ||
      (frwrd == (($past(frwrd) > `DEC_AMT) ? speed_t'($past(frwrd) - `DEC_AMT) : '0))))
    else begin
      fail_cnt++;
      $error("speed changed by a wrong step");
    end

endmodule

bind cmd_proc cmd_proc_properties props_i (
  .clk(clk), .rst_n(rst_n), .cmd_rdy(cmd_rdy), .clr_cmd_rdy(clr_cmd_rdy),
  .strt_cal(strt_cal), .tour_go(tour_go), .send_resp(send_resp), .moving(moving),
  .heading_rdy(heading_rdy), .clr_frwrd(clr_frwrd), .frwrd(frwrd),
  .state(u_cmd_fsm.state)
);

`default_nettype wire

// ==== testbench/cmd_proc_tb.sv ====
// Testbench for the knight command processor.
// Runs CAL, TOUR, MOV, FANFARE and a queued command against a gyro and
// track model. Bound assertions and a per-cycle error check judge the DUT.
`timescale 1ns/1ps
`default_nettype none

`include "knight_settings.svh"

module cmd_proc_tb;

  import knight_pkg::*;

  localparam int CLK_PERIOD  = 4;
  localparam int MOVE_CYCLES = 400;     // Worst-case turn, squares and stop.
  localparam int NUM_WAITS   = 14;      // Two bounded waits per move and queued command.

  logic        clk, rst_n, cmd_rdy, cal_done, heading_rdy;
  logic        lftIR, cntrIR, rghtIR;
  logic [15:0] cmd;
  heading_t    heading, error;
  heading_t    desired = '0;            // Model of the DUT's desired heading.
  speed_t      frwrd;
  logic        clr_cmd_rdy, send_resp, strt_cal, moving, tour_go, fanfare_go;
  logic        moving_q = 1'b0;         // moving, sampled at negedge.
  logic        cntr_prev = 1'b0;
  integer      seed = 90;
  int          err_cnt = 0, test_cnt = 0, fail_tests = 0;
  int          strt_cnt, resp_cnt, fanfare_cnt, tour_cnt, moving_cnt, edge_cnt;
  int          edges_at_resp, resp_at_accept;
  int          gyro_cnt = 0, track_cnt = 0;

  cmd_proc cmd_proc_i (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////
  // Gyro and track models
  ////////////////////////////////
  function automatic heading_t step_heading(heading_t cur, heading_t goal);
    heading_t diff;
    diff = goal - cur;                  // Wraps, so this is the short way round.
    if (diff > 12'sd64)
      return cur + 12'sd64;
    else if (diff < -12'sd64)
      return cur - 12'sd64;
    return goal;
  endfunction

  always @(posedge clk) begin
    #1;
    gyro_cnt++;
    heading_rdy = (gyro_cnt % 4 == 0);  // One gyro sample every 4 cycles.
    if (heading_rdy)
      heading = step_heading(heading, desired);
    if (moving_q) begin                 // Lines pass under the robot.
      track_cnt++;
      cntrIR = (track_cnt % 6) >= 4;
      lftIR  = ($random(seed) % 8) == 0;
      rghtIR = ($random(seed) % 8) == 0;
    end else begin
      track_cnt = 0;
      {lftIR, cntrIR, rghtIR} = 3'b000;
    end
  end

  ////////////////////////////////
  // Monitor and error check
  ////////////////////////////////
  always @(negedge clk) begin
    heading_t exp_err;
    moving_q = moving;
    if (rst_n) begin
      exp_err = heading - desired + (lftIR ? heading_t'(`NUDGE_POS) :
                rghtIR ? heading_t'(`NUDGE_NEG) : heading_t'(0));
      if (error !== exp_err) begin
        err_cnt++;
        $display("error at %0t: error is 0x%h, expected 0x%h", $time, error, exp_err);
      end
      if (cntrIR && !cntr_prev) edge_cnt++;
      if (send_resp) begin
        resp_cnt++;
        edges_at_resp = edge_cnt;
      end
      if (strt_cal) strt_cnt++;
      if (fanfare_go) fanfare_cnt++;
      if (tour_go) tour_cnt++;
      if (moving) moving_cnt++;
      if (clr_cmd_rdy) begin            // Accepted, DUT loads on the next edge.
        resp_at_accept = resp_cnt;
        edge_cnt       = 0;
        if (cmd[15:12] == MOV || cmd[15:12] == FANFARE)
          desired = (cmd[11:4] == 8'h00) ? '0 : {cmd[11:4], 4'hF};
      end
    end
    cntr_prev = cntrIR;
  end

  ////////////////////////////////
  // Tasks
  ////////////////////////////////
  function automatic int total_errs();
    return err_cnt + cmd_proc_i.props_i.fail_cnt;
  endfunction

  task automatic report_failure(input string what);
    err_cnt++;
    $display("at %0t: %s", $time, what);
  endtask

  task automatic clear_counts();
    {strt_cnt, resp_cnt, fanfare_cnt, tour_cnt, moving_cnt, edge_cnt} = '0;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    int errs;
    errs = total_errs() - errs_before;
    test_cnt++;
    if (errs != 0) fail_tests++;
    $display("test %s: %s (%0d errors)", name, (errs == 0) ? "passed" : "FAILED", errs);
  endtask

  task automatic send_cmd(input logic [15:0] c, output bit ok);
    int n;
    @(posedge clk);
    #1;
    cmd     = c;
    cmd_rdy = 1'b1;                     // Held until clr_cmd_rdy.
    n       = 0;
    ok      = 1'b0;
    while (!ok && n < MOVE_CYCLES) begin
      @(negedge clk);
      ok = clr_cmd_rdy;
      n++;
    end
    @(posedge clk);
    #1;
    cmd_rdy = 1'b0;
    if (!ok) report_failure("command was never accepted");
  endtask

  task automatic run_cal();
    int e0;
    bit ok;
    e0 = total_errs();
    clear_counts();
    send_cmd({CAL, 12'h000}, ok);
    repeat (5 + ($unsigned($random(seed)) % 16)) @(posedge clk);
    if (resp_cnt != 0) report_failure("send_resp came before cal_done");
    #1 cal_done = 1'b1;
    @(posedge clk);
    #1 cal_done = 1'b0;
    repeat (8) @(posedge clk);
    if (strt_cnt != 1) report_failure("CAL did not give exactly one strt_cal");
    if (resp_cnt != 1) report_failure("CAL did not give exactly one send_resp");
    if (moving_cnt != 0) report_failure("moving went high during CAL");
    finish_test("cal", e0);
  endtask

  task automatic run_tour();
    int e0;
    bit ok;
    e0 = total_errs();
    clear_counts();
    send_cmd({TOUR, 12'h000}, ok);
    repeat (12) @(posedge clk);
    if (tour_cnt != 1) report_failure("TOUR did not give exactly one tour_go");
    if (resp_cnt != 0 || moving_cnt != 0) report_failure("TOUR gave send_resp or moving");
    finish_test("tour", e0);
  endtask

  task automatic run_move(input opcode_t op, input logic [3:0] sq, input logic [7:0] hdg);
    int e0, n;
    bit ok;
    e0 = total_errs();
    clear_counts();
    send_cmd({op, hdg, sq}, ok);
    n = 0;
    while (resp_cnt == 0 && n < MOVE_CYCLES) begin
      @(posedge clk);
      n++;
    end
    if (resp_cnt == 0)
      report_failure("send_resp did not arrive after the move");
    else if (edges_at_resp < 2 * sq)
      report_failure("send_resp came before all squares were crossed");
    if (fanfare_cnt != (op == FANFARE)) report_failure("wrong number of fanfare_go pulses");
    finish_test($sformatf("%s %0d squares heading 0x%h",
                (op == FANFARE) ? "fanfare" : "mov", sq, hdg), e0);
  endtask

  task automatic run_busy();
    int e0;
    bit ok;
    e0 = total_errs();
    clear_counts();
    send_cmd({MOV, 8'h40, 4'd1}, ok);
    send_cmd({TOUR, 12'h000}, ok);      // Waits out the whole move.
    if (resp_at_accept != 1) report_failure("queued TOUR was accepted before send_resp");
    finish_test("queued command", e0);
  endtask

  ////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////
  initial begin
    rst_n = 1'b0;
    {cmd, cmd_rdy, cal_done, heading_rdy} = '0;
    {lftIR, cntrIR, rghtIR} = 3'b000;
    heading = '0;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    run_cal();
    run_tour();
    run_move(MOV, 4'd2, 8'h00);         // North, desired is exactly zero.
    for (int i = 0; i < 4; i++)
      run_move(i[0] ? FANFARE : MOV, 4'($unsigned($random(seed)) % 3 + 1), 8'($random(seed)));
    run_busy();
    $display("%0d tests, %0d failed, %0d errors", test_cnt, fail_tests, total_errs());
    if (total_errs() == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  initial begin
    #(CLK_PERIOD * (NUM_WAITS * MOVE_CYCLES + 300));
    $display("watchdog expired, the tests did not finish");
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+hdl
hdl/knight_pkg.sv
hdl/cmd_fsm.sv
hdl/square_counter.sv
hdl/frwrd_ramp.sv
hdl/heading_error.sv
hdl/cmd_proc.sv
testbench/cmd_proc_properties.sv
testbench/cmd_proc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the knight command processor testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module cmd_proc_tb \
  && ./obj_dir/Vcmd_proc_tb +verilator+error+limit+1000 | tee /dev/stderr \
  | grep -x "No errors" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
